// File: src/la_macros.svh
`ifndef LA_MACROS_SVH
`define LA_MACROS_SVH

// buffer address width, 2**LA_DEPTH words of sample storage
`define LA_DEPTH 5

`define LA_DIV_W 24          // sample rate divider width

`define LA_AW 5              // apb address width

// read-only identification word
`define LA_ID 32'h4c41_0105

`endif

// File: src/la_pkg.sv
`include "la_macros.svh"

package la_pkg;

  typedef logic [31:0] sample_t;                  // one probe word

  typedef logic [`LA_DEPTH-1:0] addr_t;           // buffer address

  // status flags as seen in CTRL bits 2:0
  typedef struct packed {
    logic done;                                   // readout finished
    logic triggered;                              // trigger hit since arm
    logic armed;                                  // capture waiting or collecting
  } status_t;

  // apb register offsets
  typedef enum logic [`LA_AW-1:0] {
    CTRL  = 'h00,                                 // cmd on write, status on read
    MASK  = 'h04,
    VALUE = 'h08,
    DIV   = 'h0c,
    COUNT = 'h10,                                 // samples after the trigger sample
    ID    = 'h14                                  // read only
  } reg_e;

endpackage

// File: src/la_cfg_if.sv
`timescale 1ns/1ns
`include "la_macros.svh"

interface la_cfg_if;

  la_pkg::sample_t      mask;             // bits taking part in the compare
  la_pkg::sample_t      value;            // expected level of the masked bits
  logic [`LA_DIV_W-1:0] div;              // sample every div+1 clocks
  logic                 div_wr;           // divider rewritten, restart counter
  la_pkg::addr_t        count;            // post trigger samples
  logic                 arm_pulse;
  logic                 soft_rst_pulse;

  // status, one flag per core block
  logic                 armed;
  logic                 triggered;
  logic                 done;
  la_pkg::status_t      status;

  assign status = '{done: done, triggered: triggered, armed: armed};

  modport regs (output mask, value, div, div_wr, count, arm_pulse, soft_rst_pulse,
                input  status);

  modport core (input  mask, value, div, div_wr, count, arm_pulse,
                output armed, triggered, done);

endinterface

// File: src/la_rd_if.sv
`timescale 1ns/1ns

interface la_rd_if;

  // window handed over by the capture buffer
  logic            start;                 // one cycle, window complete
  la_pkg::addr_t   first_addr;            // trigger sample
  la_pkg::addr_t   last_addr;             // last post trigger sample

  // read port of the buffer
  logic            rd_en;
  la_pkg::addr_t   rd_addr;
  la_pkg::sample_t rd_data;               // valid one cycle after rd_en

  modport buff (output start, first_addr, last_addr, rd_data,
                input  rd_en, rd_addr);

  modport rdo  (input  start, first_addr, last_addr, rd_data,
                output rd_en, rd_addr);

endinterface

// File: src/la_apb_regs.sv
`timescale 1ns/1ns
`include "la_macros.svh"

module la_apb_regs (
  input  logic              clk_i,
  input  logic              rst_n_i,
  // apb slave
  input  logic [`LA_AW-1:0] paddr_i,
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  logic [31:0]       pwdata_i,
  output logic [31:0]       prdata_o,
  output logic              pready_o,
  output logic              pslverr_o,
  // towards the core
  la_cfg_if.regs            cfg
);

  la_pkg::reg_e reg_sel;
  logic         access;                   // apb access phase
  logic         valid;                    // offset hits a register
  logic         wr;
  logic         busy;                     // capture or readout running

  assign reg_sel   = la_pkg::reg_e'(paddr_i);
  assign access    = psel_i & penable_i;
  assign wr        = access & pwrite_i & valid;
  assign pready_o  = 1'b1;                // zero wait states
  assign pslverr_o = access & ~valid;

  // triggered without done means the readout is still streaming
  assign busy = cfg.status.armed | (cfg.status.triggered & ~cfg.status.done) | cfg.arm_pulse;

  // offset decode and read mux
  always_comb begin
    valid    = 1'b1;
    prdata_o = '0;
    case (reg_sel)
      la_pkg::CTRL:  prdata_o = 32'(cfg.status);
      la_pkg::MASK:  prdata_o = cfg.mask;
      la_pkg::VALUE: prdata_o = cfg.value;
      la_pkg::DIV:   prdata_o = 32'(cfg.div);
      la_pkg::COUNT: prdata_o = 32'(cfg.count);
      la_pkg::ID:    prdata_o = `LA_ID;
      default:       valid    = 1'b0;     // unmapped offset
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg.mask           <= '0;
      cfg.value          <= '0;
      cfg.div            <= '0;
      cfg.count          <= '0;
      cfg.div_wr         <= 1'b0;
      cfg.arm_pulse      <= 1'b0;
      cfg.soft_rst_pulse <= 1'b0;
    end else begin
      // command strobes last one cycle
      cfg.div_wr         <= 1'b0;
      cfg.arm_pulse      <= 1'b0;
      cfg.soft_rst_pulse <= 1'b0;
      if (wr) begin
        case (reg_sel)
          la_pkg::CTRL: begin
            cfg.arm_pulse      <= pwdata_i[0] & ~busy;  // arm dropped while busy
            cfg.soft_rst_pulse <= pwdata_i[1];
          end
          la_pkg::MASK:  cfg.mask  <= pwdata_i;
          la_pkg::VALUE: cfg.value <= pwdata_i;
          la_pkg::DIV: begin
            cfg.div    <= pwdata_i[`LA_DIV_W-1:0];
            cfg.div_wr <= 1'b1;                        // sampler restarts its count
          end
          la_pkg::COUNT: cfg.count <= pwdata_i[`LA_DEPTH-1:0];
          default: ;                                   // ID ignores writes
        endcase
      end
    end
  end

  a_err_in_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pslverr_o |-> psel_i && penable_i);

endmodule

// File: src/la_sampler.sv
`timescale 1ns/1ns
`include "la_macros.svh"

module la_sampler (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  la_pkg::sample_t probe_i,          // probe bus
  la_cfg_if.core          cfg,
  output la_pkg::sample_t smpl_o,           // valid while smpl_stb_o
  output logic            smpl_stb_o
);

  logic [`LA_DIV_W-1:0] cnt;                // clocks left until the next sample
  logic                 hit;

  // a divider write wins over a pending hit
  assign hit = (cnt == '0) & ~cfg.div_wr;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt        <= '0;
      smpl_stb_o <= 1'b0;
    end else begin
      if (cfg.div_wr || hit) begin
        cnt <= cfg.div;                     // reload, period is div+1
      end else begin
        cnt <= cnt - 1'b1;
      end
      smpl_stb_o <= hit;                    // lines up with the registered sample
    end
  end

  // sample register
  always_ff @(posedge clk_i) begin
    if (hit) begin
      smpl_o <= probe_i;
    end
  end

endmodule

// File: src/la_trigger.sv
`timescale 1ns/1ns

module la_trigger (
  input  logic            clk_i,
  input  logic            rst_n_i,
  la_cfg_if.core          cfg,
  input  la_pkg::sample_t smpl_i,
  input  logic            smpl_stb_i,
  input  logic            armed_i,          // capture waiting or collecting
  output logic            fire_o            // one cycle on the matching sample
);

  logic match;
  logic triggered;                          // fired since the last arm

  // masked bits have to equal the masked value, mask 0 hits on any sample
  assign match  = ((smpl_i ^ cfg.value) & cfg.mask) == '0;
  assign fire_o = smpl_stb_i & armed_i & ~triggered & match;

  assign cfg.triggered = triggered;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      triggered <= 1'b0;
    end else if (cfg.arm_pulse) begin
      triggered <= 1'b0;                    // new capture round
    end else if (fire_o) begin
      triggered <= 1'b1;                    // blocks further fires
    end
  end

  // triggered only rises on a strobed sample seen while armed
  a_fire_armed: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(triggered) |-> $past(armed_i && smpl_stb_i));

endmodule

// File: src/la_capture.sv
`timescale 1ns/1ns
`include "la_macros.svh"

module la_capture (
  input  logic            clk_i,
  input  logic            rst_n_i,
  la_cfg_if.core          cfg,
  input  la_pkg::sample_t smpl_i,
  input  logic            smpl_stb_i,
  input  logic            fire_i,           // trigger sample present
  output logic            armed_o,
  la_rd_if.buff           rd
);

  typedef enum logic [1:0] {
    CP_IDLE,
    CP_ARMED,                               // waiting for the trigger
    CP_COLLECT                              // storing post trigger samples
  } cp_state_e;

  cp_state_e       state;
  la_pkg::addr_t   wr_ptr;                  // next free word, wraps
  la_pkg::addr_t   remain;                  // post trigger samples still to store
  logic            we;

  la_pkg::sample_t mem [2**`LA_DEPTH];      // sample buffer

  assign armed_o   = (state != CP_IDLE);
  assign cfg.armed = armed_o;

  // trigger sample goes in on the cycle of the match
  assign we = ((state == CP_ARMED) & fire_i) | ((state == CP_COLLECT) & smpl_stb_i);

  // buffer with registered read port
  always_ff @(posedge clk_i) begin
    if (we) begin
      mem[wr_ptr] <= smpl_i;
    end
    if (rd.rd_en) begin
      rd.rd_data <= mem[rd.rd_addr];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state         <= CP_IDLE;
      wr_ptr        <= '0;
      remain        <= '0;
      rd.start      <= 1'b0;
      rd.first_addr <= '0;
      rd.last_addr  <= '0;
    end else begin
      rd.start <= 1'b0;
      if (we) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      case (state)
        CP_IDLE: begin
          if (cfg.arm_pulse) begin
            state <= CP_ARMED;
          end
        end
        CP_ARMED: begin
          if (fire_i) begin
            rd.first_addr <= wr_ptr;
            remain        <= cfg.count;
            if (cfg.count == '0) begin
              // window is just the trigger sample
              rd.start     <= 1'b1;
              rd.last_addr <= wr_ptr;
              state        <= CP_IDLE;
            end else begin
              state <= CP_COLLECT;
            end
          end
        end
        CP_COLLECT: begin
          if (smpl_stb_i) begin
            remain <= remain - 1'b1;
            if (remain == la_pkg::addr_t'(1)) begin
              rd.start     <= 1'b1;           // last write this cycle
              rd.last_addr <= wr_ptr;
              state        <= CP_IDLE;        // armed drops with start
            end
          end
        end
        default: state <= CP_IDLE;
      endcase
    end
  end

  // buffer only written while a capture runs, never while readout reads
  a_wr_window: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    we |-> armed_o && !rd.rd_en);

endmodule

// File: src/la_readout.sv
`timescale 1ns/1ns

module la_readout (
  input  logic            clk_i,
  input  logic            rst_n_i,
  la_rd_if.rdo            rd,
  la_cfg_if.core          cfg,
  // transmitter link
  input  logic            tx_rdy_i,
  output logic            tx_stb_o,
  output la_pkg::sample_t tx_data_o
);

  typedef enum logic [1:0] {
    RO_IDLE,
    RO_READ,                                // one buffer read
    RO_SEND                                 // word on tx_data_o, wait for ready
  } ro_state_e;

  ro_state_e     state;
  la_pkg::addr_t addr;                      // word being streamed
  la_pkg::addr_t last;
  logic          done;

  assign rd.rd_en   = (state == RO_READ);
  assign rd.rd_addr = addr;

  // read data stays put until the next rd_en, so it holds under back pressure
  assign tx_data_o = rd.rd_data;
  assign tx_stb_o  = (state == RO_SEND) & tx_rdy_i;
  assign cfg.done  = done;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state <= RO_IDLE;
      addr  <= '0;
      last  <= '0;
      done  <= 1'b0;
    end else begin
      if (cfg.arm_pulse) begin
        done <= 1'b0;
      end
      case (state)
        RO_IDLE: begin
          if (rd.start) begin
            addr  <= rd.first_addr;
            last  <= rd.last_addr;
            state <= RO_READ;
          end
        end
        RO_READ: state <= RO_SEND;
        RO_SEND: begin
          if (tx_rdy_i) begin
            if (addr == last) begin
              done  <= 1'b1;
              state <= RO_IDLE;
            end else begin
              addr  <= addr + 1'b1;         // wraps with the buffer
              state <= RO_READ;
            end
          end
        end
        default: state <= RO_IDLE;
      endcase
    end
  end

  // only one word in flight, so strobes are never back to back
  a_stb_rdy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    tx_stb_o |-> tx_rdy_i ##1 !tx_stb_o);

endmodule

// File: src/la_top.sv
`timescale 1ns/1ns
`include "la_macros.svh"

module la_top (
  input  logic              clk_i,
  input  logic              rst_n_i,
  // apb
  input  logic [`LA_AW-1:0] paddr_i,
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  logic [31:0]       pwdata_i,
  output logic [31:0]       prdata_o,
  output logic              pready_o,
  output logic              pslverr_o,
  // probe and transmitter
  input  logic [31:0]       probe_i,
  input  logic              tx_rdy_i,
  output logic              tx_stb_o,
  output logic [31:0]       tx_data_o
);

  la_cfg_if u_cfg_if ();
  la_rd_if  u_rd_if ();

  logic            core_rst_n;              // board reset or soft reset command
  la_pkg::sample_t smpl;
  logic            smpl_stb;
  logic            fire;
  logic            armed;

  // soft reset clears the core but keeps the register block
  assign core_rst_n = rst_n_i & ~u_cfg_if.soft_rst_pulse;

  la_apb_regs u_apb_regs (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .paddr_i   (paddr_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .cfg       (u_cfg_if.regs)
  );

  la_sampler u_sampler (
    .clk_i      (clk_i),
    .rst_n_i    (core_rst_n),
    .probe_i    (probe_i),
    .cfg        (u_cfg_if.core),
    .smpl_o     (smpl),
    .smpl_stb_o (smpl_stb)
  );

  la_trigger u_trigger (
    .clk_i      (clk_i),
    .rst_n_i    (core_rst_n),
    .cfg        (u_cfg_if.core),
    .smpl_i     (smpl),
    .smpl_stb_i (smpl_stb),
    .armed_i    (armed),
    .fire_o     (fire)
  );

  la_capture u_capture (
    .clk_i      (clk_i),
    .rst_n_i    (core_rst_n),
    .cfg        (u_cfg_if.core),
    .smpl_i     (smpl),
    .smpl_stb_i (smpl_stb),
    .fire_i     (fire),
    .armed_o    (armed),
    .rd         (u_rd_if.buff)
  );

  la_readout u_readout (
    .clk_i     (clk_i),
    .rst_n_i   (core_rst_n),
    .rd        (u_rd_if.rdo),
    .cfg       (u_cfg_if.core),
    .tx_rdy_i  (tx_rdy_i),
    .tx_stb_o  (tx_stb_o),
    .tx_data_o (tx_data_o)
  );

endmodule

// File: verification/la_tb.sv
`timescale 1ns/1ns
`include "la_macros.svh"

module la_tb;

  logic              clk_i;
  logic              rst_n_i;
  logic [`LA_AW-1:0] paddr_i;
  logic              psel_i;
  logic              penable_i;
  logic              pwrite_i;
  logic [31:0]       pwdata_i;
  logic [31:0]       prdata_o;
  logic              pready_o;
  logic              pslverr_o;
  logic [31:0]       probe_i;
  logic              tx_rdy_i;
  logic              tx_stb_o;
  logic [31:0]       tx_data_o;

  integer               seed = 32'h13bb27d0;    // shared by all random draws
  logic                 apb_err;                // pslverr_o of the last access
  la_pkg::sample_t      rx_q[$];                // words seen on the transmitter link
  la_pkg::sample_t      smp_q[$];               // model: samples expected from the divider
  int                   smp_cyc_q[$];           // clock index of each model sample
  int                   cyc;
  int                   next_stb;
  int                   arm_cyc;                // first sample index eligible after arm
  logic [`LA_DIV_W-1:0] div_m;
  bit                   sampling;
  int                   plant_wait;             // cycles before the planned word
  int                   plant_left;
  la_pkg::sample_t      plant_word;
  logic [31:0]          rd;
  logic [31:0]          cfg_v[24];              // drawn at time zero, before any clock

  la_top u_la_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      stop_run($sformatf("** Error @ %0t ns: %s is %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_sample(input string what, input la_pkg::sample_t got,
                              input la_pkg::sample_t exp);
    if (got !== exp)
      stop_run($sformatf("** Error @ %0t ns: %s is %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_status(input string what, input la_pkg::status_t got,
                              input la_pkg::status_t exp);
    if (got !== exp)
      stop_run($sformatf("** Error @ %0t ns: %s is %b, expected %b (done/trig/armed)",
                         $time, what, got, exp));
  endtask

  function automatic la_pkg::status_t status_of(input logic done, trig, armed);
    la_pkg::status_t s;
    s.done      = done;
    s.triggered = trig;
    s.armed     = armed;
    return s;
  endfunction

  task automatic apb_write(input logic [`LA_AW-1:0] addr, input logic [31:0] data);
    @(posedge clk_i);
    paddr_i   <= addr;                          // setup phase
    pwdata_i  <= data;
    pwrite_i  <= 1'b1;
    psel_i    <= 1'b1;
    @(posedge clk_i);
    penable_i <= 1'b1;
    @(posedge clk_i);                           // end of access phase, register updates
    apb_err   = pslverr_o;
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b0;
  endtask

  task automatic apb_read(input logic [`LA_AW-1:0] addr, output logic [31:0] data);
    @(posedge clk_i);
    paddr_i   <= addr;
    pwrite_i  <= 1'b0;
    psel_i    <= 1'b1;
    @(posedge clk_i);
    penable_i <= 1'b1;
    @(posedge clk_i);
    data      = prdata_o;                       // valid in the access phase
    apb_err   = pslverr_o;
    check_word("pready_o", 32'(pready_o), 32'h1);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  // polls CTRL until one status bit is set
  task automatic wait_ctrl_bit(input int idx, input string what);
    logic [31:0] v;
    int          n;
    n = 0;
    apb_read(la_pkg::CTRL, v);
    while (!v[idx]) begin
      n++;
      if (n > 2000) stop_run($sformatf("timeout: %s never showed up in CTRL status", what));
      apb_read(la_pkg::CTRL, v);
    end
  endtask

  // random probe words and ready, a planned word held 8 clocks when asked for
  always @(posedge clk_i) begin
    if (plant_left > 0 && plant_wait == 0) begin
      probe_i <= plant_word;
      plant_left = plant_left - 1;
    end else begin
      probe_i <= $random(seed);
      if (plant_wait > 0) plant_wait = plant_wait - 1;
    end
    tx_rdy_i <= ($random(seed) % 3) != 0;     // low about a third of the time
  end

  // sample model, strobes counted from the DIV write, period div+1
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      sampling = 1'b0;
    end else if (psel_i && penable_i && pwrite_i && paddr_i == la_pkg::DIV) begin
      div_m    = pwdata_i[`LA_DIV_W-1:0];
      next_stb = cyc + 2 + div_m;               // one clock to reload, then div+1
      sampling = 1'b1;
      smp_q.delete();
      smp_cyc_q.delete();
    end else if (psel_i && penable_i && pwrite_i && paddr_i == la_pkg::CTRL) begin
      if (pwdata_i[1]) sampling = 1'b0;         // soft reset restarts the divider count
      else if (pwdata_i[0]) arm_cyc = cyc + 1;
    end
    if (sampling && cyc == next_stb) begin
      smp_q.push_back(probe_i);
      smp_cyc_q.push_back(cyc);
      next_stb = cyc + div_m + 1;
    end
    cyc = cyc + 1;
  end

  // transmitter monitor
  always @(posedge clk_i) begin
    if (rst_n_i && tx_stb_o) begin
      if (!tx_rdy_i) stop_run($sformatf("** Error @ %0t ns: strobe with tx_rdy_i low", $time));
      rx_q.push_back(tx_data_o);
    end
  end

  // one capture round, window compared against the model
  task automatic run_capture(input logic [31:0] mask, input logic [31:0] value,
                             input logic [`LA_DIV_W-1:0] div, input logic [4:0] count,
                             input bit planned);
    logic [31:0] v;
    int          first;
    first = -1;
    apb_write(la_pkg::MASK, mask);
    apb_write(la_pkg::VALUE, value);
    apb_write(la_pkg::COUNT, 32'(count));
    apb_write(la_pkg::DIV, 32'(div));
    rx_q.delete();
    if (planned) begin
      plant_word = value;
      plant_left = 8;                           // longer than the largest divider period
      plant_wait = 60;
    end
    apb_write(la_pkg::CTRL, 32'h1);             // arm
    apb_read(la_pkg::CTRL, v);
    check_word("done after arm", 32'(v[2]), 32'h0);
    if (planned) check_status("status after arm", la_pkg::status_t'(v[2:0]), status_of(0, 0, 1));
    wait_ctrl_bit(1, "trigger");
    wait_ctrl_bit(2, "readout done");
    apb_read(la_pkg::CTRL, v);
    check_status("status after readout", la_pkg::status_t'(v[2:0]), status_of(1, 1, 0));
    foreach (smp_q[i])
      if (first < 0 && smp_cyc_q[i] >= arm_cyc && (smp_q[i] & mask) == (value & mask)) first = i;
    if (first < 0 || first + count >= smp_q.size())
      stop_run("model holds no complete capture window for this round");
    check_word("strobe count", rx_q.size(), count + 1);
    if (planned) check_sample("first word under mask", rx_q[0] & mask, value & mask);
    for (int i = 0; i <= count; i++)
      check_sample($sformatf("window word %0d", i), rx_q[i], smp_q[first + i]);
  endtask

  initial begin
    foreach (cfg_v[i]) cfg_v[i] = $random(seed);
    rst_n_i = 1'b0;
    paddr_i = '0;
    psel_i = 1'b0;
    penable_i = 1'b0;
    pwrite_i = 1'b0;
    pwdata_i = '0;
    probe_i = '0;
    tx_rdy_i = 1'b0;
    cyc = 0;
    arm_cyc = 0;
    plant_wait = 0;
    plant_left = 0;
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // reset values, read back, ID and bad offsets
    for (int a = 0; a <= 'h10; a += 4) begin
      apb_read(a[`LA_AW-1:0], rd);
      check_word($sformatf("reset value at %h", a), rd, 32'h0);
      check_word($sformatf("pslverr on read at %h", a), 32'(apb_err), 32'h0);
    end
    apb_read(la_pkg::ID, rd);
    check_word("ID", rd, `LA_ID);
    apb_write(la_pkg::MASK, cfg_v[0]);
    apb_write(la_pkg::VALUE, cfg_v[1]);
    apb_write(la_pkg::DIV, cfg_v[2]);
    apb_write(la_pkg::COUNT, cfg_v[3]);
    apb_read(la_pkg::MASK, rd);
    check_word("MASK", rd, cfg_v[0]);
    apb_read(la_pkg::VALUE, rd);
    check_word("VALUE", rd, cfg_v[1]);
    apb_read(la_pkg::DIV, rd);
    check_word("DIV", rd, cfg_v[2] & 32'h00ff_ffff);   // 24 bit divider
    apb_read(la_pkg::COUNT, rd);
    check_word("COUNT", rd, cfg_v[3] & 32'h1f);
    apb_write(la_pkg::ID, ~`LA_ID);
    check_word("pslverr on ID write", 32'(apb_err), 32'h0);
    apb_read(la_pkg::ID, rd);
    check_word("ID after write", rd, `LA_ID);
    apb_write(5'h18, 32'hffff_ffff);
    check_word("pslverr on bad write", 32'(apb_err), 32'h1);
    apb_read(5'h18, rd);
    check_word("pslverr on bad read", 32'(apb_err), 32'h1);
    apb_read(la_pkg::MASK, rd);
    check_word("MASK after bad write", rd, cfg_v[0]);

    // mask 0 rounds first, then planned trigger words
    for (int r = 0; r < 3; r++)
      run_capture(32'h0, cfg_v[4 + r], cfg_v[8 + r] & 7, cfg_v[12 + r][4:0], 1'b0);
    for (int r = 0; r < 3; r++)
      run_capture(cfg_v[16 + r] | 32'h00ff_ff00, cfg_v[20 + r], cfg_v[8 + r] & 3,
                  cfg_v[12 + r][4:0], 1'b1);

    // soft reset while collecting a long window
    apb_write(la_pkg::MASK, 32'h0);
    apb_write(la_pkg::COUNT, 32'd31);
    apb_write(la_pkg::DIV, 32'd7);
    rx_q.delete();
    apb_write(la_pkg::CTRL, 32'h1);
    wait_ctrl_bit(1, "trigger before soft reset");
    apb_read(la_pkg::CTRL, rd);
    check_status("status while collecting", la_pkg::status_t'(rd[2:0]), status_of(0, 1, 1));
    apb_write(la_pkg::CTRL, 32'h2);
    apb_read(la_pkg::CTRL, rd);
    check_status("status after soft reset", la_pkg::status_t'(rd[2:0]), status_of(0, 0, 0));
    repeat (300) @(posedge clk_i);              // longer than the aborted window
    check_word("strobes after soft reset", rx_q.size(), 32'h0);

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// File: src.f
+incdir+src
src/la_pkg.sv
src/la_cfg_if.sv
src/la_rd_if.sv
src/la_apb_regs.sv
src/la_sampler.sv
src/la_trigger.sv
src/la_capture.sv
src/la_readout.sv
src/la_top.sv
verification/la_tb.sv
